/* fma_pkg.sv */
// =========================================================================
// fma package: lane sizing, latencies, opcode and rounding encodings, and
// the request, operand and result records shared by the FMA blocks
// =========================================================================
package fma_pkg;

    localparam int N_LANES   = 4;
    localparam int TAG_W     = 4;
    localparam int MUL_STEPS = 12;
    localparam int CORE_LAT  = 17;
    localparam int TOP_LAT   = 19;
    localparam int EXP_BIAS  = 127;
    // adder field and its leading-zero count width
    localparam int SUM_W     = 76;
    localparam int LZ_W      = 7;

    localparam logic [31:0] QNAN   = 32'h7FC0_0000;
    localparam logic [31:0] FP_ONE = 32'h3F80_0000;

    typedef enum logic [2:0] {
        OP_FMADD  = 3'd0,
        OP_FMSUB  = 3'd1,
        OP_FNMSUB = 3'd2,
        OP_FNMADD = 3'd3,
        OP_FADD   = 3'd4,
        OP_FSUB   = 3'd5,
        OP_FMUL   = 3'd6
    } fma_op_e;

    typedef enum logic [2:0] {
        RM_RNE = 3'd0,
        RM_RTZ = 3'd1,
        RM_RDN = 3'd2,
        RM_RUP = 3'd3,
        RM_RMM = 3'd4
    } rnd_mode_e;

    // fclass order, neg_inf is bit 0
    typedef struct packed {
        logic qnan;
        logic snan;
        logic pos_inf;
        logic pos_norm;
        logic pos_sub;
        logic pos_zero;
        logic neg_zero;
        logic neg_sub;
        logic neg_norm;
        logic neg_inf;
    } fp_class_t;

    typedef struct packed {
        logic nv;
        logic of;
        logic uf;
        logic nx;
    } fma_flags_t;

    typedef struct packed {
        fma_op_e          op;
        rnd_mode_e        rm;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      c;
        logic [TAG_W-1:0] tag;
    } fma_req_t;

    typedef struct packed {
        fp_class_t   cls;
        logic        sign;
        logic [7:0]  exp;
        logic [23:0] mant;
    } fp_unpacked_t;

    typedef struct packed {
        logic [31:0]      word;
        fma_flags_t       flags;
        logic [TAG_W-1:0] tag;
    } fma_res_t;

endpackage

/* fp_classify.sv */
// =========================================================================
// binary32 operand decoder: one-hot class plus sign, exponent, mantissa
// =========================================================================
`timescale 1ns/100ps

module fp_classify (
    input  logic [31:0]           word_i,
    output fma_pkg::fp_unpacked_t unp_o
);
    logic [7:0]  e;
    logic [22:0] f;
    logic        s;
    logic        e_max;
    logic        e_zero;
    logic        f_zero;

    assign s      = word_i[31];
    assign e      = word_i[30:23];
    assign f      = word_i[22:0];
    assign e_max  = &e;
    assign e_zero = ~|e;
    assign f_zero = ~|f;

    always_comb begin
        unp_o.cls.qnan     = e_max & f[22];
        unp_o.cls.snan     = e_max & ~f_zero & ~f[22];
        unp_o.cls.pos_inf  = ~s & e_max & f_zero;
        unp_o.cls.pos_norm = ~s & ~e_max & ~e_zero;
        unp_o.cls.pos_sub  = ~s & e_zero & ~f_zero;
        unp_o.cls.pos_zero = ~s & e_zero & f_zero;
        unp_o.cls.neg_zero = s & e_zero & f_zero;
        unp_o.cls.neg_sub  = s & e_zero & ~f_zero;
        unp_o.cls.neg_norm = s & ~e_max & ~e_zero;
        unp_o.cls.neg_inf  = s & e_max & f_zero;
        unp_o.sign         = s;
        // subnormals and zero sit at exponent 1 with no hidden bit
        unp_o.exp          = e_zero ? 8'd1 : e;
        unp_o.mant         = {|e, f};
    end

endmodule

/* mul_radix4.sv */
// =========================================================================
// sequential radix-4 mantissa multiplier, two multiplier bits per cycle
// =========================================================================
`timescale 1ns/100ps

module mul_radix4 (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start_i,
    input  logic [23:0] a_i,
    input  logic [23:0] b_i,
    output logic [47:0] prod_o,
    output logic        done_o
);
    import fma_pkg::*;

    localparam int CNT_W = $clog2(MUL_STEPS + 1);

    logic [CNT_W-1:0] cnt_q;
    logic             active_q;
    logic [47:0]      mcand_q;
    logic [23:0]      mplier_q;
    logic [47:0]      pp;

    // 0, 1, 2 or 3 times the multiplicand
    always_comb begin
        case (mplier_q[1:0])
            2'd0:    pp = '0;
            2'd1:    pp = mcand_q;
            2'd2:    pp = mcand_q << 1;
            default: pp = mcand_q + (mcand_q << 1);
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_q    <= '0;
            active_q <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                cnt_q    <= CNT_W'(MUL_STEPS);
                active_q <= 1'b1;
            end else if (active_q) begin
                if (cnt_q != '0) begin
                    cnt_q <= cnt_q - 1'b1;
                end else begin
                    active_q <= 1'b0;
                    done_o   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            mcand_q  <= {24'b0, a_i};
            mplier_q <= b_i;
            prod_o   <= '0;
        end else if (active_q && cnt_q != '0) begin
            prod_o   <= prod_o + pp;
            mcand_q  <= mcand_q << 2;
            mplier_q <= mplier_q >> 2;
        end
    end

endmodule

/* lzc.sv */
// =========================================================================
// leading-zero counter over the adder field
// =========================================================================
`timescale 1ns/100ps

module lzc (
    input  logic [fma_pkg::SUM_W-1:0] data_i,
    output logic [fma_pkg::LZ_W-1:0]  count_o,
    output logic                      zero_o
);
    import fma_pkg::*;

    // highest set bit wins, scan runs upward
    always_comb begin
        count_o = LZ_W'(SUM_W);
        for (int i = 0; i < SUM_W; i++) begin
            if (data_i[i]) begin
                count_o = LZ_W'(SUM_W - 1 - i);
            end
        end
    end

    assign zero_o = ~|data_i;

endmodule

/* fp_round.sv */
// =========================================================================
// binary32 rounding and packing: applies rm, handles overflow, sets flags
// =========================================================================
`timescale 1ns/100ps

module fp_round (
    input  logic                signed [9:0] exp_i,
    input  logic                sign_i,
    input  logic [23:0]         mant_i,
    input  logic [2:0]          grs_i,
    input  fma_pkg::rnd_mode_e  rm_i,
    input  logic                special_i,
    input  logic [31:0]         special_word_i,
    input  logic                nv_i,
    output logic [31:0]         word_o,
    output fma_pkg::fma_flags_t flags_o
);
    import fma_pkg::*;

    logic              inexact;
    logic              inc;
    logic              ovf;
    logic              to_max;
    logic [24:0]       mant_r;
    logic signed [9:0] exp_r;

    always_comb begin
        inexact = |grs_i;
        case (rm_i)
            RM_RNE:  inc = grs_i[2] & (mant_i[0] | (|grs_i[1:0]));
            RM_RTZ:  inc = 1'b0;
            RM_RDN:  inc = sign_i & inexact;
            RM_RUP:  inc = ~sign_i & inexact;
            RM_RMM:  inc = grs_i[2];
            default: inc = 1'b0;
        endcase

        mant_r = {1'b0, mant_i} + {24'b0, inc};
        exp_r  = exp_i;
        // carry out of the mantissa bumps the exponent
        if (mant_r[24]) begin
            mant_r = mant_r >> 1;
            exp_r  = exp_i + 10'sd1;
        end
        ovf    = exp_r >= 10'sd255;
        to_max = (rm_i == RM_RTZ) | ((rm_i == RM_RDN) & ~sign_i) | ((rm_i == RM_RUP) & sign_i);

        flags_o = '0;
        if (special_i) begin
            word_o     = special_word_i;
            flags_o.nv = nv_i;
        end else if (ovf) begin
            word_o     = to_max ? {sign_i, 8'hFE, 23'h7F_FFFF} : {sign_i, 8'hFF, 23'h0};
            flags_o.of = 1'b1;
            flags_o.nx = 1'b1;
        end else begin
            // no hidden bit means subnormal or zero
            word_o     = {sign_i, mant_r[23] ? exp_r[7:0] : 8'h00, mant_r[22:0]};
            flags_o.uf = ~mant_i[23] & inexact;
            flags_o.nx = inexact;
        end
    end

endmodule

/* fma_core.sv */
// =========================================================================
// single FMA lane: unpack, multiply, align and add, normalize, round
// fixed latency from start to done for every operation
// =========================================================================
`timescale 1ns/100ps

module fma_core (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_i,
    input  fma_pkg::fma_req_t req_i,
    output logic              busy_o,
    output logic              done_o,
    output fma_pkg::fma_res_t res_o
);
    import fma_pkg::*;

    typedef enum logic [2:0] {IDLE, PREP, MUL_WAIT, ADD, NORM, RND} state_e;

    state_e             state_q;
    fma_req_t           req_q;
    logic [31:0]        a_w, b_w, c_w;
    fp_unpacked_t       ua, ub, uc;
    logic               sp, sc, p_inf, c_inf, any_nan, inv;
    logic [31:0]        pre_word;
    logic               sp_q, sc_q, pzero_q, special_q, nv_q;
    logic [31:0]        sword_q;
    logic signed [9:0]  ep_q, ec_q;
    logic [23:0]        mc_q;
    logic [47:0]        prod;
    logic               mul_done;
    logic signed [9:0]  ediff, e_al, eal_q;
    logic [SUM_W-1:0]   p_al, c_al, sum, mag, mag_q;
    logic               sgn, sign_q;
    logic [LZ_W-1:0]    lz;
    logic               lzero;
    logic [SUM_W-1:0]   nsh;
    logic signed [9:0]  e_n, en_q;
    logic [23:0]        nm_q;
    logic [2:0]         grs_q;
    logic [31:0]        rnd_word;
    fma_flags_t         rnd_flags;

    // right shift that folds the lost bits into bit 0
    function automatic logic [SUM_W-1:0] shr_sticky(input logic [SUM_W-1:0] x,
                                                    input logic [9:0] sh);
        logic [SUM_W-1:0] y;
        logic             lost;
        if (sh >= SUM_W) begin
            y    = '0;
            lost = |x;
        end else begin
            y    = x >> sh;
            lost = |(x & ~({SUM_W{1'b1}} << sh));
        end
        return {y[SUM_W-1:1], y[0] | lost};
    endfunction

    fp_classify u_cls_a (.word_i(a_w), .unp_o(ua));
    fp_classify u_cls_b (.word_i(b_w), .unp_o(ub));
    fp_classify u_cls_c (.word_i(c_w), .unp_o(uc));

    mul_radix4 u_mul (
        .clk    (clk),
        .rst_n  (rst_n),
        .start_i(state_q == PREP),
        .a_i    (ua.mant),
        .b_i    (ub.mant),
        .prod_o (prod),
        .done_o (mul_done)
    );

    lzc u_lzc (.data_i(mag_q), .count_o(lz), .zero_o(lzero));

    fp_round u_round (
        .sign_i        (sign_q),
        .exp_i         (en_q),
        .mant_i        (nm_q),
        .grs_i         (grs_q),
        .rm_i          (req_q.rm),
        .special_i     (special_q),
        .special_word_i(sword_q),
        .nv_i          (nv_q),
        .word_o        (rnd_word),
        .flags_o       (rnd_flags)
    );

    // operand substitution, effective signs and special cases
    always_comb begin
        a_w = req_q.a;
        b_w = req_q.b;
        c_w = req_q.c;
        if (req_q.op inside {OP_FADD, OP_FSUB}) begin
            b_w = FP_ONE;
            c_w = req_q.b;
        end
        if (req_q.op == OP_FMUL) begin
            c_w = {req_q.a[31] ^ req_q.b[31], 31'b0};
        end
        sp      = ua.sign ^ ub.sign ^ (req_q.op inside {OP_FNMSUB, OP_FNMADD});
        sc      = uc.sign ^ (req_q.op inside {OP_FMSUB, OP_FNMADD, OP_FSUB});
        p_inf   = ua.cls.pos_inf | ua.cls.neg_inf | ub.cls.pos_inf | ub.cls.neg_inf;
        c_inf   = uc.cls.pos_inf | uc.cls.neg_inf;
        any_nan = ua.cls.snan | ua.cls.qnan | ub.cls.snan | ub.cls.qnan
                | uc.cls.snan | uc.cls.qnan;
        inv     = ua.cls.snan | ub.cls.snan | uc.cls.snan
                | ((ua.cls.pos_inf | ua.cls.neg_inf) & (ub.cls.pos_zero | ub.cls.neg_zero))
                | ((ub.cls.pos_inf | ub.cls.neg_inf) & (ua.cls.pos_zero | ua.cls.neg_zero))
                | (p_inf & c_inf & (sp != sc) & ~any_nan);
        pre_word = (any_nan | inv) ? QNAN : {p_inf ? sp : sc, 8'hFF, 23'h0};
    end

    // alignment of the smaller term and the signed add
    always_comb begin
        ediff = ep_q - ec_q;
        if (ediff < 0 || pzero_q) begin
            e_al = ec_q;
            p_al = pzero_q ? '0 : shr_sticky({2'b0, prod, 26'b0}, 10'(-ediff));
            c_al = {3'b0, mc_q, 49'b0};
        end else begin
            e_al = ep_q;
            p_al = {2'b0, prod, 26'b0};
            c_al = shr_sticky({3'b0, mc_q, 49'b0}, 10'(ediff));
        end
        sum = (sp_q ? -p_al : p_al) + (sc_q ? -c_al : c_al);
        mag = sum[SUM_W-1] ? -sum : sum;
        if (~|sum) begin
            sgn = (sp_q == sc_q) ? sp_q : (req_q.rm == RM_RDN);
        end else begin
            sgn = sum[SUM_W-1];
        end
    end

    // leading one to the top, then back down for subnormals
    always_comb begin
        nsh = mag_q << lz;
        e_n = eal_q + 10'sd3 - 10'(lz);
        if (lzero) begin
            e_n = 10'sd1;
        end else if (e_n < 10'sd1) begin
            nsh = shr_sticky(nsh, 10'sd1 - e_n);
            e_n = 10'sd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:     if (start_i) state_q <= PREP;
                PREP:     state_q <= MUL_WAIT;
                MUL_WAIT: if (mul_done) state_q <= ADD;
                ADD:      state_q <= NORM;
                NORM:     state_q <= RND;
                default:  state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_i) begin
            req_q <= req_i;
        end
        if (state_q == PREP) begin
            sp_q      <= sp;
            sc_q      <= sc;
            pzero_q   <= ua.cls.pos_zero | ua.cls.neg_zero | ub.cls.pos_zero | ub.cls.neg_zero;
            special_q <= any_nan | inv | p_inf | c_inf;
            nv_q      <= inv;
            sword_q   <= pre_word;
            ep_q      <= 10'(ua.exp) + 10'(ub.exp) - 10'(EXP_BIAS);
            ec_q      <= 10'(uc.exp);
            mc_q      <= uc.mant;
        end
        if (state_q == MUL_WAIT && mul_done) begin
            mag_q  <= mag;
            sign_q <= sgn;
            eal_q  <= e_al;
        end
        if (state_q == ADD) begin
            nm_q  <= nsh[SUM_W-1 -: 24];
            grs_q <= {nsh[51], nsh[50], |nsh[49:0]};
            en_q  <= e_n;
        end
        if (state_q == NORM) begin
            res_o.word  <= rnd_word;
            res_o.flags <= rnd_flags;
            res_o.tag   <= req_q.tag;
        end
    end

    assign busy_o = state_q != IDLE;
    assign done_o = state_q == RND;

endmodule

/* fma_dispatch.sv */
// =========================================================================
// request dispatcher: tags each accepted request and starts the lowest
// free lane
// =========================================================================
`timescale 1ns/100ps

module fma_dispatch (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        valid_i,
    input  fma_pkg::fma_req_t           req_i,
    input  logic [fma_pkg::N_LANES-1:0] lane_busy_i,
    output logic                        busy_o,
    output logic [fma_pkg::N_LANES-1:0] lane_start_o,
    output fma_pkg::fma_req_t           lane_req_o
);
    import fma_pkg::*;

    logic [N_LANES-1:0] free;
    logic [N_LANES-1:0] pick;
    logic [TAG_W-1:0]   tag_q;
    logic               accept;

    // a lane being started this cycle does not show busy yet
    assign free   = ~(lane_busy_i | lane_start_o);
    assign pick   = free & (~free + 1'b1);
    assign busy_o = ~|free;
    assign accept = valid_i & ~busy_o;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lane_start_o <= '0;
            tag_q        <= '0;
        end else begin
            lane_start_o <= accept ? pick : '0;
            if (accept) begin
                tag_q <= tag_q + 1'b1;
            end
        end
    end

    // shared request register, read by the lane on its start edge
    always_ff @(posedge clk) begin
        if (accept) begin
            lane_req_o     <= req_i;
            lane_req_o.tag <= tag_q;
        end
    end

endmodule

/* fma_collect.sv */
// =========================================================================
// result collector: registers the finishing lane and keeps sticky flags
// =========================================================================
`timescale 1ns/100ps

module fma_collect (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [fma_pkg::N_LANES-1:0] lane_done_i,
    input  fma_pkg::fma_res_t           lane_res_i [fma_pkg::N_LANES],
    input  logic                        flags_clr_i,
    output logic                        result_valid_o,
    output fma_pkg::fma_res_t           result_o,
    output fma_pkg::fma_flags_t         flags_o
);
    import fma_pkg::*;

    fma_res_t sel;
    logic     any_done;

    // done is one-hot at most, so an OR mux is enough
    always_comb begin
        sel = '0;
        for (int i = 0; i < N_LANES; i++) begin
            if (lane_done_i[i]) begin
                sel = sel | lane_res_i[i];
            end
        end
    end

    assign any_done = |lane_done_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid_o <= 1'b0;
            flags_o        <= '0;
        end else begin
            result_valid_o <= any_done;
            // clear first, a result in the same cycle still sets
            flags_o        <= (flags_clr_i ? '0 : flags_o) | (any_done ? sel.flags : '0);
        end
    end

    always_ff @(posedge clk) begin
        if (any_done) begin
            result_o <= sel;
        end
    end

endmodule

/* fma_top.sv */
// =========================================================================
// multi-lane binary32 FMA unit: dispatcher, parallel lanes, collector
// =========================================================================
`timescale 1ns/100ps

module fma_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid_i,
    input  fma_pkg::fma_req_t   req_i,
    input  logic                flags_clr_i,
    output logic                busy_o,
    output logic                result_valid_o,
    output fma_pkg::fma_res_t   result_o,
    output fma_pkg::fma_flags_t flags_o
);
    import fma_pkg::*;

    logic [N_LANES-1:0] lane_start;
    logic [N_LANES-1:0] lane_busy;
    logic [N_LANES-1:0] lane_done;
    fma_req_t           lane_req;
    fma_res_t           lane_res [N_LANES];

    fma_dispatch u_dispatch (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_i     (valid_i),
        .req_i       (req_i),
        .lane_busy_i (lane_busy),
        .busy_o      (busy_o),
        .lane_start_o(lane_start),
        .lane_req_o  (lane_req)
    );

    for (genvar i = 0; i < N_LANES; i++) begin : lane
        fma_core u_core (
            .clk    (clk),
            .rst_n  (rst_n),
            .start_i(lane_start[i]),
            .req_i  (lane_req),
            .busy_o (lane_busy[i]),
            .done_o (lane_done[i]),
            .res_o  (lane_res[i])
        );
    end

    fma_collect u_collect (
        .clk           (clk),
        .rst_n         (rst_n),
        .lane_done_i   (lane_done),
        .lane_res_i    (lane_res),
        .flags_clr_i   (flags_clr_i),
        .result_valid_o(result_valid_o),
        .result_o      (result_o),
        .flags_o       (flags_o)
    );

endmodule

/* fma_sva.sv */
// ==========================================================================
// bound checks on the FMA top: one-hot start and done, tag order, reset
// ==========================================================================
`timescale 1ns/100ps

module fma_sva (
    input logic                        clk,
    input logic                        rst_n,
    input logic [fma_pkg::N_LANES-1:0] lane_start,
    input logic [fma_pkg::N_LANES-1:0] lane_done,
    input logic                        busy_o,
    input logic                        result_valid_o,
    input fma_pkg::fma_res_t           result_o
);
    import fma_pkg::*;

    logic [TAG_W-1:0] last_tag;
    logic             seen;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seen <= 1'b0;
        end else if (result_valid_o) begin
            seen     <= 1'b1;
            last_tag <= result_o.tag;
        end
    end

    done_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(lane_done))
        else $error("more than one lane finished in a cycle");

    start_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(lane_start))
        else $error("more than one lane started in a cycle");

    tag_order: assert property (@(posedge clk) disable iff (!rst_n)
        (result_valid_o && seen) |-> result_o.tag == TAG_W'(last_tag + 1'b1))
        else $error("result tag out of order");

    busy_after_reset: assert property (@(posedge clk) !rst_n |=> !busy_o)
        else $error("busy_o high after reset");

endmodule

bind fma_top fma_sva u_sva (
    .clk           (clk),
    .rst_n         (rst_n),
    .lane_start    (lane_start),
    .lane_done     (lane_done),
    .busy_o        (busy_o),
    .result_valid_o(result_valid_o),
    .result_o      (result_o)
);

/* fma_tb.sv */
// ==========================================================================
// testbench for the multi-lane binary32 FMA unit with a table of vectors,
// in-order result checking, sticky flag checks and a cycle limit
// ==========================================================================
`timescale 1ns/100ps

module fma_tb;
    import fma_pkg::*;

    typedef struct packed {
        fma_op_e     op;
        rnd_mode_e   rm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] word;
        fma_flags_t  flags;
        logic        gap;
    } vec_t;

    localparam fma_flags_t F_NONE = 4'b0000;
    localparam fma_flags_t F_NV   = 4'b1000;
    localparam fma_flags_t F_OFNX = 4'b0101;
    localparam fma_flags_t F_UFNX = 4'b0011;
    localparam fma_flags_t F_NX   = 4'b0001;

    logic       clk;
    logic       rst_n;
    logic       valid_i;
    fma_req_t   req_i;
    logic       flags_clr_i;
    logic       busy_o;
    logic       result_valid_o;
    fma_res_t   result_o;
    fma_flags_t flags_o;

    vec_t       vectors[$];
    fma_res_t   expected[$];
    int         issued_at[$];
    fma_res_t   want;
    fma_flags_t sticky;
    int         received;
    int         cycles;
    int         limit;
    int         latency;
    logic       full_seen;

    fma_top dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid_i       (valid_i),
        .req_i         (req_i),
        .flags_clr_i   (flags_clr_i),
        .busy_o        (busy_o),
        .result_valid_o(result_valid_o),
        .result_o      (result_o),
        .flags_o       (flags_o)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic add_vec(input fma_op_e op, input rnd_mode_e rm, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] c,
                           input logic [31:0] word, input fma_flags_t flags,
                           input logic gap);
        vectors.push_back('{op, rm, a, b, c, word, flags, gap});
    endtask

    // expected words worked out by hand from binary32 encodings
    task automatic load_table();
        // exact results with the first four issued back to back
        add_vec(OP_FMADD,  RM_RNE, 32'h3FC00000, 32'h40000000, 32'h3E800000, 32'h40500000, F_NONE, 0);
        add_vec(OP_FMSUB,  RM_RNE, 32'h40000000, 32'h40400000, 32'h3F800000, 32'h40A00000, F_NONE, 0);
        add_vec(OP_FNMSUB, RM_RNE, 32'h40000000, 32'h40400000, 32'h3F800000, 32'hC0A00000, F_NONE, 0);
        add_vec(OP_FNMADD, RM_RNE, 32'h40000000, 32'h40400000, 32'h3F800000, 32'hC0E00000, F_NONE, 0);
        add_vec(OP_FADD,   RM_RNE, 32'h3F800000, 32'h40000000, 32'h00000000, 32'h40400000, F_NONE, 0);
        add_vec(OP_FSUB,   RM_RNE, 32'h3F800000, 32'h3E800000, 32'h00000000, 32'h3F400000, F_NONE, 1);
        add_vec(OP_FMUL,   RM_RNE, 32'h40400000, 32'h3F000000, 32'h00000000, 32'h3FC00000, F_NONE, 1);
        add_vec(OP_FMUL,   RM_RNE, 32'hC0000000, 32'h40400000, 32'h00000000, 32'hC0C00000, F_NONE, 0);
        // exact cancellation where the sign of zero follows rm
        add_vec(OP_FMADD,  RM_RNE, 32'h3F800000, 32'h3F800000, 32'hBF800000, 32'h00000000, F_NONE, 1);
        add_vec(OP_FMADD,  RM_RDN, 32'h3F800000, 32'h3F800000, 32'hBF800000, 32'h80000000, F_NONE, 1);
        // 1.0 + 3*2^-24 is a tie with odd lsb
        add_vec(OP_FADD,   RM_RNE, 32'h3F800000, 32'h34400000, 32'h00000000, 32'h3F800002, F_NX, 0);
        add_vec(OP_FADD,   RM_RTZ, 32'h3F800000, 32'h34400000, 32'h00000000, 32'h3F800001, F_NX, 1);
        add_vec(OP_FADD,   RM_RDN, 32'h3F800000, 32'h34400000, 32'h00000000, 32'h3F800001, F_NX, 0);
        add_vec(OP_FADD,   RM_RUP, 32'h3F800000, 32'h34400000, 32'h00000000, 32'h3F800002, F_NX, 1);
        add_vec(OP_FADD,   RM_RMM, 32'h3F800000, 32'h34400000, 32'h00000000, 32'h3F800002, F_NX, 0);
        add_vec(OP_FADD,   RM_RDN, 32'hBF800000, 32'hB4400000, 32'h00000000, 32'hBF800002, F_NX, 1);
        add_vec(OP_FADD,   RM_RUP, 32'hBF800000, 32'hB4400000, 32'h00000000, 32'hBF800001, F_NX, 0);
        // NaN, invalid and infinite operands
        add_vec(OP_FMADD,  RM_RNE, 32'h7FC00000, 32'h3F800000, 32'h3F800000, QNAN, F_NONE, 1);
        add_vec(OP_FMADD,  RM_RNE, 32'h7F800001, 32'h3F800000, 32'h3F800000, QNAN, F_NV, 0);
        add_vec(OP_FMUL,   RM_RNE, 32'h7F800000, 32'h00000000, 32'h00000000, QNAN, F_NV, 1);
        add_vec(OP_FSUB,   RM_RNE, 32'h7F800000, 32'h7F800000, 32'h00000000, QNAN, F_NV, 0);
        add_vec(OP_FADD,   RM_RNE, 32'h7F800000, 32'h3F800000, 32'h00000000, 32'h7F800000, F_NONE, 1);
        // overflow of max-finite times two
        add_vec(OP_FMUL,   RM_RNE, 32'h7F7FFFFF, 32'h40000000, 32'h00000000, 32'h7F800000, F_OFNX, 0);
        add_vec(OP_FMUL,   RM_RTZ, 32'h7F7FFFFF, 32'h40000000, 32'h00000000, 32'h7F7FFFFF, F_OFNX, 1);
        // (1+2^-23)*2^-130 lands in the subnormal range with a lost bit
        add_vec(OP_FMUL,   RM_RNE, 32'h3D800001, 32'h00800000, 32'h00000000, 32'h00080000, F_UFNX, 0);
        add_vec(OP_FMUL,   RM_RUP, 32'h3D800001, 32'h00800000, 32'h00000000, 32'h00080001, F_UFNX, 1);
    endtask

    // results are compared in issue order
    always @(negedge clk) begin
        if (rst_n && result_valid_o) begin
            if (expected.size() == 0) begin
                abort_run("a result arrived with no request outstanding");
            end else begin
                want    = expected.pop_front();
                latency = cycles - issued_at.pop_front();
                sticky  = sticky | want.flags;
                assert (result_o.word == want.word)
                    else report_mismatch("result word", result_o.word, want.word);
                assert (result_o.flags == want.flags)
                    else report_mismatch("result flags", 32'(result_o.flags), 32'(want.flags));
                assert (result_o.tag == want.tag)
                    else report_mismatch("result tag", 32'(result_o.tag), 32'(want.tag));
                assert (latency == TOP_LAT)
                    else report_mismatch("result latency", 32'(latency), 32'(TOP_LAT));
                assert (flags_o == sticky)
                    else report_mismatch("sticky flags", 32'(flags_o), 32'(sticky));
                received++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            abort_run("timeout: results never arrived within the cycle limit");
        end
    end

    initial begin
        int gap;
        void'($urandom(32'h960b_0516));
        clk         = 1'b0;
        rst_n       = 1'b0;
        valid_i     = 1'b0;
        req_i       = '0;
        flags_clr_i = 1'b0;
        sticky      = '0;
        received    = 0;
        cycles      = 0;
        latency     = 0;
        full_seen   = 1'b0;
        load_table();
        limit = vectors.size() * (TOP_LAT + 8) + 100;

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        for (int i = 0; i < vectors.size(); i++) begin
            gap = vectors[i].gap ? int'($urandom % 4) : 0;
            if (gap > 0) begin
                valid_i <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            valid_i   <= 1'b1;
            req_i.op  <= vectors[i].op;
            req_i.rm  <= vectors[i].rm;
            req_i.a   <= vectors[i].a;
            req_i.b   <= vectors[i].b;
            req_i.c   <= vectors[i].c;
            req_i.tag <= '0;
            // held while busy and taken at the first edge with busy low
            @(negedge clk);
            while (busy_o) begin
                full_seen = 1'b1;
                @(negedge clk);
            end
            expected.push_back('{vectors[i].word, vectors[i].flags, TAG_W'(i)});
            // the next rising edge samples the request
            issued_at.push_back(cycles + 1);
            @(posedge clk);
        end
        valid_i <= 1'b0;

        assert (full_seen)
            else abort_run("busy_o never rose with all lanes in use");

        while (received < vectors.size()) begin
            @(negedge clk);
        end
        assert (flags_o == sticky)
            else report_mismatch("final sticky flags", 32'(flags_o), 32'(sticky));

        @(posedge clk);
        flags_clr_i <= 1'b1;
        @(posedge clk);
        flags_clr_i <= 1'b0;
        @(negedge clk);
        assert (flags_o == '0)
            else report_mismatch("flags after clear", 32'(flags_o), 32'h0);

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* filelist.f */
fma_pkg.sv
fp_classify.sv
mul_radix4.sv
lzc.sv
fp_round.sv
fma_core.sv
fma_dispatch.sv
fma_collect.sv
fma_top.sv
fma_sva.sv
fma_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module fma_tb -o fma_sim
./obj_dir/fma_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "NO ERRORS" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
